/* logic/hand_link_pkg.sv */
`default_nettype none

package hand_link_pkg;

  // one camera coordinate, 12 bits from the hand tracker
  typedef logic [11:0] coord_t;

  // one hand sample
  // field order matches the frame byte order
  typedef struct packed {
    coord_t x_top;
    coord_t y_top;
    coord_t x_bot;
    coord_t y_bot;
  } hand_pos_t;

  // received byte plus stop-bit status
  typedef struct packed {
    logic [7:0] data;
    logic       err;
  } frame_byte_t;

  // byte slot within a frame, 0 to 8
  typedef logic [3:0] frame_idx_t;

  // 65 MHz / 115200 baud, rounded
  localparam int unsigned clks_per_bit = 564;
  // start edge to start-bit middle
  localparam int unsigned clks_half_bit = 282;

  // frame layout
  // three 0xFF sync bytes, then six payload bytes
  localparam logic [7:0]  sync_byte = 8'hFF;
  localparam int unsigned sync_len  = 3;
  localparam int unsigned data_len  = 6;
  localparam int unsigned frame_len = sync_len + data_len;

endpackage

`default_nettype wire

/* logic/uart_tx.sv */
`default_nettype none

module uart_tx (
  input  wire        clk_65mhz,
  input  wire        sys_rst,
  input  wire  [7:0] tx_byte,
  input  wire        tx_valid,
  output logic       tx_ready,
  output logic       txd
);

  // stop, data lsb first, start in bit 0
  logic [9:0] shift_q;
  // counts cycles inside one bit period
  logic [9:0] clk_cnt;
  // counts bits 0 (start) to 9 (stop)
  logic [3:0] bit_cnt;
  logic       busy;
  logic       accept;
  logic       bit_end;

  assign accept  = tx_valid && tx_ready;
  assign bit_end = (clk_cnt == 10'(hand_link_pkg::clks_per_bit - 1));

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      busy     <= 1'b0;
      tx_ready <= 1'b1;
      txd      <= 1'b1;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
    end else begin
      if (accept) begin
        // line drops on the next edge
        busy     <= 1'b1;
        tx_ready <= 1'b0;
        clk_cnt  <= '0;
        bit_cnt  <= '0;
      end else if (busy) begin
        if (bit_end) begin
          clk_cnt <= '0;
          // stop bit done, release the line
          if (bit_cnt == 4'd9) begin
            busy <= 1'b0;
          end else begin
            bit_cnt <= bit_cnt + 4'd1;
          end
        end else begin
          clk_cnt <= clk_cnt + 10'd1;
        end
      end else begin
        // one cycle after the stop bit has fully ended
        tx_ready <= 1'b1;
      end
      // registered line, idle high
      txd <= busy ? shift_q[0] : 1'b1;
    end
  end

  // frame bits, loaded on accept and shifted each bit period
  always_ff @(posedge clk_65mhz) begin
    if (accept) begin
      shift_q <= {1'b1, tx_byte, 1'b0};
    end else if (busy && bit_end) begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
`default_nettype none

module uart_rx (
  input  wire                        clk_65mhz,
  input  wire                        sys_rst,
  input  wire                        rxd,
  output hand_link_pkg::frame_byte_t rx_byte,
  output logic                       rx_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t  state;
  // two-flop synchronizer, then one more for edge detect
  logic       rxd_meta;
  logic       rxd_sync;
  logic       rxd_prev;
  logic [9:0] clk_cnt;
  logic [2:0] bit_idx;
  logic [7:0] shift_q;
  logic       half_end;
  logic       bit_end;

  assign half_end = (clk_cnt == 10'(hand_link_pkg::clks_half_bit - 1));
  assign bit_end  = (clk_cnt == 10'(hand_link_pkg::clks_per_bit - 1));

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
      state    <= st_idle;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
      rx_valid <= 1'b0;
      case (state)
        st_idle: begin
          // falling edge on the line
          if (rxd_prev && !rxd_sync) begin
            state   <= st_start;
            clk_cnt <= '0;
          end
        end
        st_start: begin
          if (half_end) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // high again at mid start means a glitch
            state   <= rxd_sync ? st_idle : st_data;
          end else begin
            clk_cnt <= clk_cnt + 10'd1;
          end
        end
        st_data: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end
          end else begin
            clk_cnt <= clk_cnt + 10'd1;
          end
        end
        st_stop: begin
          // report at stop-bit middle, error or not
          if (bit_end) begin
            rx_valid <= 1'b1;
            state    <= st_idle;
          end else begin
            clk_cnt <= clk_cnt + 10'd1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk_65mhz) begin
    if (state == st_data && bit_end) begin
      shift_q <= {rxd_sync, shift_q[7:1]};
    end
    if (state == st_stop && bit_end) begin
      rx_byte.data <= shift_q;
      // low stop bit is a framing error
      rx_byte.err  <= !rxd_sync;
    end
  end

endmodule

`default_nettype wire

/* logic/hand_frame_tx.sv */
`default_nettype none

module hand_frame_tx (
  input  wire                      clk_65mhz,
  input  wire                      sys_rst,
  input  wire hand_link_pkg::hand_pos_t pos,
  input  wire                      pos_valid,
  output logic                     pos_ready,
  output logic [7:0]               tx_byte,
  output logic                     tx_valid,
  input  wire                      tx_ready
);

  // sample held for the whole frame
  hand_link_pkg::hand_pos_t   pos_q;
  // current byte slot
  hand_link_pkg::frame_idx_t  idx;
  // high from accept until the ninth byte is taken
  logic                       active;
  logic                       take_pos;
  logic                       byte_done;
  logic                       last_slot;

  assign pos_ready = !active;
  assign tx_valid  = active;
  assign take_pos  = pos_valid && pos_ready;
  assign byte_done = tx_valid && tx_ready;
  assign last_slot =
    (idx == hand_link_pkg::frame_idx_t'(hand_link_pkg::frame_len - 1));

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      active <= 1'b0;
      idx    <= '0;
    end else if (take_pos) begin
      // byte 0 is offered in the next cycle
      active <= 1'b1;
      idx    <= '0;
    end else if (byte_done) begin
      if (last_slot) begin
        // whole frame handed over, ready for the next sample
        active <= 1'b0;
      end else begin
        idx <= idx + 4'd1;
      end
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (take_pos) begin
      pos_q <= pos;
    end
  end

  // slot to byte mapping
  // low nibble byte goes before the packed byte for each hand point
  always_comb begin
    case (idx)
      4'd3: begin
        tx_byte = pos_q.x_top[11:4];
      end
      4'd4: begin
        tx_byte = pos_q.y_top[7:0];
      end
      4'd5: begin
        tx_byte = {pos_q.x_top[3:0], pos_q.y_top[11:8]};
      end
      4'd6: begin
        tx_byte = pos_q.x_bot[11:4];
      end
      4'd7: begin
        tx_byte = pos_q.y_bot[7:0];
      end
      4'd8: begin
        tx_byte = {pos_q.x_bot[3:0], pos_q.y_bot[11:8]};
      end
      // slots 0 to 2
      default: begin
        tx_byte = hand_link_pkg::sync_byte;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/hand_frame_rx.sv */
`default_nettype none

module hand_frame_rx (
  input  wire                            clk_65mhz,
  input  wire                            sys_rst,
  input  wire hand_link_pkg::frame_byte_t rx_byte,
  input  wire                            rx_valid,
  output hand_link_pkg::hand_pos_t       out_pos,
  output logic                           out_valid
);

  // high once the sync run has been seen
  logic                                       locked;
  logic [1:0]                                 sync_cnt;
  hand_link_pkg::frame_idx_t                  data_cnt;
  // first five payload bytes, oldest in the top byte
  logic [8*(hand_link_pkg::data_len-1)-1:0]   pay_q;
  // all six payload bytes once the last arrives
  logic [8*hand_link_pkg::data_len-1:0]       full;
  logic                                       is_sync;
  logic                                       last_byte;

  assign is_sync   = !rx_byte.err && (rx_byte.data == hand_link_pkg::sync_byte);
  assign last_byte =
    (data_cnt == hand_link_pkg::frame_idx_t'(hand_link_pkg::data_len - 1));
  assign full      = {pay_q, rx_byte.data};

  always_ff @(posedge clk_65mhz) begin
    if (sys_rst) begin
      locked    <= 1'b0;
      sync_cnt  <= '0;
      data_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (rx_valid) begin
        if (!locked) begin
          // hunting, count back-to-back clean sync bytes
          if (is_sync) begin
            if (sync_cnt == 2'(hand_link_pkg::sync_len - 1)) begin
              locked   <= 1'b1;
              sync_cnt <= '0;
              data_cnt <= '0;
            end else begin
              sync_cnt <= sync_cnt + 2'd1;
            end
          end else begin
            sync_cnt <= '0;
          end
        end else if (rx_byte.err) begin
          // bad stop bit, drop the frame silently
          locked <= 1'b0;
        end else if (last_byte) begin
          locked    <= 1'b0;
          out_valid <= 1'b1;
        end else begin
          // payload may be 0xFF, taken as data anyway
          data_cnt <= data_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_65mhz) begin
    if (rx_valid && locked) begin
      pay_q <= {pay_q[$high(pay_q)-8:0], rx_byte.data};
    end
    if (rx_valid && locked && !rx_byte.err && last_byte) begin
      // bytes 0..5 sit at full[47:40] down to full[7:0]
      out_pos.x_top <= {full[47:40], full[31:28]};
      out_pos.y_top <= {full[27:24], full[39:32]};
      out_pos.x_bot <= {full[23:16], full[7:4]};
      out_pos.y_bot <= {full[3:0], full[15:8]};
    end
  end

endmodule

`default_nettype wire

/* logic/hand_link_top.sv */
`default_nettype none

module hand_link_top (
  input  wire                      clk_65mhz,
  input  wire                      sys_rst,
  input  wire hand_link_pkg::hand_pos_t pos,
  input  wire                      pos_valid,
  output logic                     pos_ready,
  output logic                     txd,
  input  wire                      rxd,
  output hand_link_pkg::hand_pos_t out_pos,
  output logic                     out_valid
);

  // framer to serializer
  logic [7:0]                 tx_byte;
  logic                       tx_valid;
  logic                       tx_ready;
  // deserializer to deframer
  hand_link_pkg::frame_byte_t rx_byte;
  logic                       rx_valid;

  // transmit path
  hand_frame_tx frame_tx (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .pos       (pos),
    .pos_valid (pos_valid),
    .pos_ready (pos_ready),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready)
  );

  uart_tx serializer (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .tx_byte   (tx_byte),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .txd       (txd)
  );

  // receive path, rxd kept separate from txd
  uart_rx deserializer (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .rxd       (rxd),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid)
  );

  hand_frame_rx frame_rx (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .out_pos   (out_pos),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

/* test/tb_line_monitor.sv */
`default_nettype none

module tb_line_monitor (
  input  wire                        clk_65mhz,
  input  wire                        sys_rst,
  input  wire                        line,
  output hand_link_pkg::frame_byte_t rec_byte,
  output logic                       rec_valid
);

  // line level at the previous falling edge
  logic       prev;
  logic [7:0] data;
  logic       stop_bit;

  // line sampled on the falling edge, where it is stable
  initial begin
    rec_byte  = '0;
    rec_valid = 1'b0;
    prev      = 1'b1;
    forever begin
      @(negedge clk_65mhz);
      if (sys_rst) begin
        prev = 1'b1;
      end else if (prev && !line) begin
        // start edge seen, go to the start-bit middle
        repeat (hand_link_pkg::clks_half_bit) @(negedge clk_65mhz);
        if (!line) begin
          // lsb first, one full bit apart
          for (int i = 0; i < 8; i++) begin
            repeat (hand_link_pkg::clks_per_bit) @(negedge clk_65mhz);
            data[i] = line;
          end
          repeat (hand_link_pkg::clks_per_bit) @(negedge clk_65mhz);
          stop_bit = line;
          // pulse from one rising edge to the next
          @(posedge clk_65mhz);
          rec_byte.data = data;
          rec_byte.err  = !stop_bit;
          rec_valid     = 1'b1;
          @(posedge clk_65mhz);
          rec_valid = 1'b0;
          prev      = stop_bit;
        end else begin
          // glitch, back to idle
          prev = 1'b1;
        end
      end else begin
        prev = line;
      end
    end
  end

endmodule

`default_nettype wire

/* test/hand_link_tb.sv */
`default_nettype none

module hand_link_tb;

  // one frame is about 50,800 cycles
  localparam int tmo_cycles = 70000;

  logic                       clk_65mhz;
  logic                       sys_rst;
  hand_link_pkg::hand_pos_t   pos;
  logic                       pos_valid;
  logic                       pos_ready;
  logic                       txd;
  logic                       rxd;
  hand_link_pkg::hand_pos_t   out_pos;
  logic                       out_valid;
  // high: rxd follows txd, low: rxd driven by bang_byte
  logic                       loopback;
  logic                       bb_line;
  hand_link_pkg::frame_byte_t mon_byte;
  logic                       mon_valid;
  logic [31:0]                rng;
  int                         errors;
  int                         checks;
  int                         tests;
  logic [7:0]                 wire_q[$];
  hand_link_pkg::hand_pos_t   got_q[$];

  assign rxd = loopback ? txd : bb_line;

  hand_link_top uut (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .pos       (pos),
    .pos_valid (pos_valid),
    .pos_ready (pos_ready),
    .txd       (txd),
    .rxd       (rxd),
    .out_pos   (out_pos),
    .out_valid (out_valid)
  );

  tb_line_monitor mon (
    .clk_65mhz (clk_65mhz),
    .sys_rst   (sys_rst),
    .line      (txd),
    .rec_byte  (mon_byte),
    .rec_valid (mon_valid)
  );

  initial begin
    clk_65mhz = 1'b0;
    forever begin
      #2 clk_65mhz = ~clk_65mhz;
    end
  end

  // wire bytes from the monitor, samples from the DUT
  always @(negedge clk_65mhz) begin
    if (mon_valid) begin
      wire_q.push_back(mon_byte.data);
      // every byte on txd ends with a high stop bit
      checks++;
      if (mon_byte.err) begin
        errors++;
        $display("Mismatch at %0t: stop bit on txd is low, expected high", $time);
      end
    end
    if (out_valid) begin
      got_q.push_back(out_pos);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // nine wire bytes of a sample, byte 0 in the top bits
  function automatic logic [71:0] model_frame(input hand_link_pkg::hand_pos_t p);
    return {24'hFF_FFFF, p.x_top[11:4], p.y_top[7:0], p.x_top[3:0], p.y_top[11:8],
            p.x_bot[11:4], p.y_bot[7:0], p.x_bot[3:0], p.y_bot[11:8]};
  endfunction

  task automatic next_pos(output hand_link_pkg::hand_pos_t p);
    logic [31:0] hi;
    rng = xorshift(rng);
    hi  = rng;
    rng = xorshift(rng);
    p   = {hi, rng[15:0]};
  endtask

  // offer a sample and return once taken
  // seen >= 0 also checks the byte count when pos_ready rises
  task automatic send_sample(input hand_link_pkg::hand_pos_t p, input int seen);
    int t;
    pos       = p;
    pos_valid = 1'b1;
    t         = 0;
    while (!pos_ready && t < tmo_cycles) begin
      @(negedge clk_65mhz);
      t++;
    end
    if (!pos_ready) begin
      errors++;
      $display("timeout: pos_ready never rose, at %0t", $time);
    end else if (seen >= 0) begin
      checks++;
      if (wire_q.size() != seen) begin
        errors++;
        $display("Mismatch at %0t: pos_ready rose after %0d bytes, expected %0d",
                 $time, wire_q.size(), seen);
      end
    end
    @(negedge clk_65mhz);
    pos_valid = 1'b0;
  endtask

  task automatic wait_counts(input int nbytes, input int nouts);
    int t;
    t = 0;
    while ((wire_q.size() < nbytes || got_q.size() < nouts) && t < tmo_cycles) begin
      @(posedge clk_65mhz);
      t++;
    end
    if (wire_q.size() < nbytes || got_q.size() < nouts) begin
      errors++;
      $display("timeout: %0d bytes and %0d samples never arrived, at %0t",
               nbytes, nouts, $time);
    end
    @(negedge clk_65mhz);
  endtask

  // frame bytes on the wire, then exactly one sample out
  task automatic check_frame(input hand_link_pkg::hand_pos_t p, input int nbytes);
    logic [71:0]              want;
    logic [7:0]               b;
    hand_link_pkg::hand_pos_t got;
    want = model_frame(p);
    wait_counts(nbytes, 1);
    for (int i = 0; i < nbytes && wire_q.size() > 0; i++) begin
      b = wire_q.pop_front();
      checks++;
      if (b !== want[71-8*i -: 8]) begin
        errors++;
        $display("Mismatch at %0t: wire byte %0d is %h, expected %h",
                 $time, i, b, want[71-8*i -: 8]);
      end
    end
    if (got_q.size() > 0) begin
      got = got_q.pop_front();
      checks++;
      if (got !== p) begin
        errors++;
        $display("Mismatch at %0t: sample %h, expected %h", $time, got, p);
      end
    end
    if (wire_q.size() != 0 || got_q.size() != 0) begin
      errors++;
      $display("extra bytes or samples left after a frame, at %0t", $time);
    end
  endtask

  // 8N1 byte on rxd, then two idle bits so a low stop bit recovers
  task automatic bang_byte(input logic [7:0] b, input logic stop_bit);
    logic [9:0] bits;
    bits = {stop_bit, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      bb_line = bits[i];
      repeat (hand_link_pkg::clks_per_bit) @(negedge clk_65mhz);
    end
    bb_line = 1'b1;
    repeat (2 * hand_link_pkg::clks_per_bit) @(negedge clk_65mhz);
  endtask

  task automatic bang_frame(input logic [71:0] bytes, input int bad_slot);
    for (int i = 0; i < 9; i++) begin
      bang_byte(bytes[71-8*i -: 8], i != bad_slot);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
  endtask

  initial begin
    hand_link_pkg::hand_pos_t pa;
    hand_link_pkg::hand_pos_t pb;
    logic [7:0]               b;
    int                       e0;
    sys_rst   = 1'b1;
    pos       = '0;
    pos_valid = 1'b0;
    loopback  = 1'b1;
    bb_line   = 1'b1;
    rng       = 32'h3ee8_1d88;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    repeat (2) @(negedge clk_65mhz);
    sys_rst = 1'b0;

    e0 = errors;
    for (int n = 0; n < 3; n++) begin
      next_pos(pa);
      // random idle gap before the sample
      rng = xorshift(rng);
      repeat (rng[5:0]) @(negedge clk_65mhz);
      send_sample(pa, -1);
      check_frame(pa, 9);
    end
    end_test("wire format", e0);

    // all ones first, nine 0xFF bytes in a row
    e0 = errors;
    pa = '1;
    send_sample(pa, -1);
    check_frame(pa, 9);
    for (int n = 0; n < 2; n++) begin
      next_pos(pa);
      pa.x_top[11:4] = 8'hFF;
      pa.y_bot[7:0]  = 8'hFF;
      send_sample(pa, -1);
      check_frame(pa, 9);
    end
    end_test("round trip", e0);

    // second sample held while the first frame is on the wire
    e0 = errors;
    next_pos(pa);
    next_pos(pb);
    send_sample(pa, -1);
    send_sample(pb, 8);
    check_frame(pa, 9);
    check_frame(pb, 9);
    end_test("back-pressure", e0);

    // noise with a broken sync run, then one good frame
    e0 = errors;
    loopback = 1'b0;
    for (int n = 0; n < 6; n++) begin
      rng = xorshift(rng);
      b   = (rng[7:0] == 8'hFF) ? 8'h00 : rng[7:0];
      bang_byte(b, 1'b1);
      if (n == 3) begin
        bang_byte(8'hFF, 1'b1);
        bang_byte(8'hFF, 1'b1);
      end
    end
    next_pos(pa);
    bang_frame(model_frame(pa), -1);
    check_frame(pa, 0);
    end_test("resync", e0);

    // no 0xFF payload, so the tail cannot fake a sync run
    e0 = errors;
    next_pos(pa);
    pa  = hand_link_pkg::hand_pos_t'(pa & 48'h7F7_F7F_7F7_F7F);
    rng = xorshift(rng);
    bang_frame(model_frame(pa), 3 + int'(rng % 6));
    checks++;
    if (got_q.size() != 0) begin
      errors++;
      $display("a frame with a bad stop bit still gave a sample, at %0t", $time);
    end
    next_pos(pb);
    bang_frame(model_frame(pb), -1);
    check_frame(pb, 0);
    end_test("framing error", e0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
logic/hand_link_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/hand_frame_tx.sv
logic/hand_frame_rx.sv
logic/hand_link_top.sv
test/tb_line_monitor.sv
test/hand_link_tb.sv

/* Bender.yml */
package:
  name: hand_link

sources:
  - logic/hand_link_pkg.sv
  - logic/uart_tx.sv
  - logic/uart_rx.sv
  - logic/hand_frame_tx.sv
  - logic/hand_frame_rx.sv
  - logic/hand_link_top.sv
  - target: test
    files:
      - test/tb_line_monitor.sv
      - test/hand_link_tb.sv
